// ==== sim.f ====
rtl/rv_pkg.sv
rtl/rv_fetch.sv
rtl/rv_decode.sv
rtl/rv_operand_fetch.sv
rtl/rv_execute.sv
rtl/rv_writeback.sv
rtl/rv_hart.sv
verif/tb_rv_mem.sv
verif/tb_rv_hart.sv

// ==== Bender.yml ====
package:
  name: rv_hart

sources:
  - rtl/rv_pkg.sv
  - rtl/rv_fetch.sv
  - rtl/rv_decode.sv
  - rtl/rv_operand_fetch.sv
  - rtl/rv_execute.sv
  - rtl/rv_writeback.sv
  - rtl/rv_hart.sv
  - target: test
    files:
      - verif/tb_rv_mem.sv
      - verif/tb_rv_hart.sv

// ==== verif/tb_rv_hart.sv ====
module tb_rv_hart;
	timeunit 1ns;
	timeprecision 100ps;

	localparam rv_pkg::word_t reset_pc = 32'h0;
	localparam int n_tests = 8;
	localparam int store_timeout = 400;

	logic          clock;
	logic          reset;
	logic          stall_en;
	logic          inst_req;
	rv_pkg::word_t inst_addr;
	logic          inst_done;
	rv_pkg::word_t inst_data;
	logic          data_req;
	logic          data_wren;
	rv_pkg::word_t data_addr;
	rv_pkg::word_t data_wdata;
	logic          data_done;
	rv_pkg::word_t data_rdata;

	// --------------------------------------------------
	// test table
	// --------------------------------------------------

	string         t_name  [n_tests];
	rv_pkg::word_t t_prog  [n_tests][8];
	logic          t_stall [n_tests];
	int            t_nst   [n_tests];
	rv_pkg::word_t t_addr  [n_tests][4];
	rv_pkg::word_t t_data  [n_tests][4];

	// stores seen on the data port, in order
	rv_pkg::word_t st_addr_q [$];
	rv_pkg::word_t st_data_q [$];

	int errors;
	int failed_tests;

	rv_hart #(
		.reset_pc_p (reset_pc),
		.sp_init_p  (32'h0003F000)
	) rv_hart_i (
		.clock_i     (clock),
		.reset_i     (reset),
		.inst_req_o  (inst_req),
		.inst_addr_o (inst_addr),
		.inst_done_i (inst_done),
		.inst_data_i (inst_data),
		.data_req_o  (data_req),
		.data_wren_o (data_wren),
		.data_addr_o (data_addr),
		.data_data_o (data_wdata),
		.data_done_i (data_done),
		.data_data_i (data_rdata)
	);

	tb_rv_mem tb_rv_mem_i (
		.clock_i      (clock),
		.reset_i      (reset),
		.stall_en_i   (stall_en),
		.inst_addr_i  (inst_addr),
		.data_req_i   (data_req),
		.data_wren_i  (data_wren),
		.data_addr_i  (data_addr),
		.data_wdata_i (data_wdata),
		.inst_done_o  (inst_done),
		.inst_data_o  (inst_data),
		.data_done_o  (data_done),
		.data_rdata_o (data_rdata)
	);

	always #50 clock = ~clock;

	// store monitor
	always @(posedge clock) begin
		if (reset && data_req && data_wren) begin
			st_addr_q.push_back(data_addr);
			st_data_q.push_back(data_wdata);
		end
	end

	// --------------------------------------------------
	// instruction encoders
	// --------------------------------------------------

	function automatic rv_pkg::word_t i_type(input logic [11:0] imm, input logic [4:0] rs1,
		input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] opc);
		return {imm, rs1, f3, rd, opc};
	endfunction

	function automatic rv_pkg::word_t s_type(input logic [11:0] imm, input logic [4:0] rs2,
		input logic [4:0] rs1, input logic [2:0] f3);
		return {imm[11:5], rs2, rs1, f3, imm[4:0], 7'b0100011};
	endfunction

	function automatic rv_pkg::word_t r_type(input logic [6:0] f7, input logic [4:0] rs2,
		input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd);
		return {f7, rs2, rs1, f3, rd, 7'b0110011};
	endfunction

	function automatic rv_pkg::word_t u_type(input logic [19:0] imm, input logic [4:0] rd,
		input logic [6:0] opc);
		return {imm, rd, opc};
	endfunction

	task automatic compare(input string name, input string what,
		input rv_pkg::word_t exp, input rv_pkg::word_t act);
		if (exp !== act) begin
			errors++;
			$display("[ERROR] %s %s expected %h actual %h", name, what, exp, act);
		end
	endtask

	task automatic set_store(input int t, input int s, input rv_pkg::word_t a,
		input rv_pkg::word_t d);
		t_addr[t][s] = a;
		t_data[t][s] = d;
		t_nst[t] = s + 1;
	endtask

	task automatic build_table();
		for (int t = 0; t < n_tests; t++) begin
			t_stall[t] = 1'b0;
			t_nst[t] = 0;
			for (int k = 0; k < 8; k++) begin
				t_prog[t][k] = 32'h00000013;
			end
		end
		// lui, auipc at address 8
		t_name[0] = "upper_imm";
		t_prog[0][0] = u_type(20'h12345, 1, 7'b0110111);
		t_prog[0][1] = s_type(12'h200, 1, 0, 3'b010);
		t_prog[0][2] = u_type(20'h00001, 3, 7'b0010111);
		t_prog[0][3] = s_type(12'h204, 3, 0, 3'b010);
		set_store(0, 0, 32'h200, 32'h12345000);
		set_store(0, 1, 32'h204, 32'h00001008);
		// addi from x2, slli, xori, srai
		t_name[1] = "imm_alu";
		t_prog[1][0] = i_type(12'hFF0, 2, 3'b000, 1, 7'b0010011);
		t_prog[1][1] = s_type(12'h200, 1, 0, 3'b010);
		t_prog[1][2] = i_type(12'h004, 1, 3'b001, 3, 7'b0010011);
		t_prog[1][3] = s_type(12'h204, 3, 0, 3'b010);
		t_prog[1][4] = i_type(12'hFFF, 1, 3'b100, 4, 7'b0010011);
		t_prog[1][5] = i_type(12'h404, 4, 3'b101, 5, 7'b0010011);
		t_prog[1][6] = s_type(12'h208, 5, 0, 3'b010);
		set_store(1, 0, 32'h200, 32'h0003EFF0);
		set_store(1, 1, 32'h204, 32'h003EFF00);
		set_store(1, 2, 32'h208, 32'hFFFFC100);
		// sub, sra, sltu chained on previous results
		t_name[2] = "reg_fwd";
		t_prog[2][0] = i_type(12'd100, 0, 3'b000, 1, 7'b0010011);
		t_prog[2][1] = i_type(12'h800, 0, 3'b000, 2, 7'b0010011);
		t_prog[2][2] = r_type(7'h20, 2, 1, 3'b000, 3);
		t_prog[2][3] = r_type(7'h20, 3, 2, 3'b101, 4);
		t_prog[2][4] = r_type(7'h00, 4, 3, 3'b011, 5);
		t_prog[2][5] = s_type(12'h200, 3, 0, 3'b010);
		t_prog[2][6] = s_type(12'h204, 4, 0, 3'b010);
		t_prog[2][7] = s_type(12'h208, 5, 0, 3'b010);
		set_store(2, 0, 32'h200, 32'h00000864);
		set_store(2, 1, 32'h204, 32'hFFFFFF80);
		set_store(2, 2, 32'h208, 32'h00000001);
		// lb, lh, lbu, lhu of 8765f0a3
		t_name[3] = "load_ext";
		t_prog[3][0] = i_type(12'h100, 0, 3'b000, 2, 7'b0000011);
		t_prog[3][1] = i_type(12'h100, 0, 3'b001, 3, 7'b0000011);
		t_prog[3][2] = i_type(12'h100, 0, 3'b100, 4, 7'b0000011);
		t_prog[3][3] = i_type(12'h100, 0, 3'b101, 5, 7'b0000011);
		for (int s = 0; s < 4; s++) begin
			t_prog[3][4+s] = s_type(12'h200 + 12'(4 * s), 5'(2 + s), 0, 3'b010);
		end
		set_store(3, 0, 32'h200, 32'hFFFFFFA3);
		set_store(3, 1, 32'h204, 32'hFFFFF0A3);
		set_store(3, 2, 32'h208, 32'h000000A3);
		set_store(3, 3, 32'h20C, 32'h0000F0A3);
		// lw, then sb and sh send the whole register
		t_name[4] = "word_store";
		t_prog[4][0] = i_type(12'h100, 0, 3'b010, 1, 7'b0000011);
		t_prog[4][1] = u_type(20'hCAFE1, 2, 7'b0110111);
		t_prog[4][2] = i_type(12'h5B7, 2, 3'b000, 2, 7'b0010011);
		t_prog[4][3] = s_type(12'h200, 1, 0, 3'b010);
		t_prog[4][4] = s_type(12'h205, 2, 0, 3'b000);
		t_prog[4][5] = s_type(12'h20A, 2, 0, 3'b001);
		set_store(4, 0, 32'h200, 32'h8765F0A3);
		set_store(4, 1, 32'h205, 32'hCAFE15B7);
		set_store(4, 2, 32'h20A, 32'hCAFE15B7);
		// load result used at once by add and by a store
		t_name[5] = "load_use";
		t_prog[5][0] = i_type(12'h123, 0, 3'b000, 3, 7'b0010011);
		t_prog[5][1] = i_type(12'h100, 0, 3'b010, 1, 7'b0000011);
		t_prog[5][2] = r_type(7'h00, 3, 1, 3'b000, 4);
		t_prog[5][3] = s_type(12'h200, 4, 0, 3'b010);
		t_prog[5][4] = i_type(12'h104, 0, 3'b010, 5, 7'b0000011);
		t_prog[5][5] = s_type(12'h204, 5, 0, 3'b010);
		set_store(5, 0, 32'h200, 32'h8765F1C6);
		set_store(5, 1, 32'h204, 32'h1BBE4182);
		// same programs with random done stalls
		for (int k = 0; k < 2; k++) begin
			t_name[6+k] = {t_name[2+3*k], "_stall"};
			t_prog[6+k] = t_prog[2+3*k];
			t_stall[6+k] = 1'b1;
			t_nst[6+k] = t_nst[2+3*k];
			t_addr[6+k] = t_addr[2+3*k];
			t_data[6+k] = t_data[2+3*k];
		end
	endtask

	// --------------------------------------------------
	// test sequence
	// --------------------------------------------------

	task automatic apply_reset(input string name);
		@(posedge clock);
		#1;
		reset = 1'b0;
		repeat (5) @(posedge clock);
		#1;
		compare(name, "reset data_req", 1'b0, data_req);
		compare(name, "reset data_wren", 1'b0, data_wren);
		compare(name, "reset inst_req", 1'b1, inst_req);
		compare(name, "reset inst_addr", reset_pc, inst_addr);
		st_addr_q.delete();
		st_data_q.delete();
		reset = 1'b1;
	endtask

	task automatic run_test(input int t);
		int start_errors;
		int cycles;
		logic timed_out;
		start_errors = errors;
		timed_out = 1'b0;
		// the program sits at address zero, where fetch starts
		for (int k = 0; k < 64; k++) begin
			tb_rv_mem_i.imem[k] = 32'h00000013;
		end
		for (int k = 0; k < 8; k++) begin
			tb_rv_mem_i.imem[k] = t_prog[t][k];
		end
		stall_en = t_stall[t];
		apply_reset(t_name[t]);
		for (int s = 0; s < t_nst[t] && !timed_out; s++) begin
			cycles = 0;
			while (st_addr_q.size() <= s && cycles < store_timeout) begin
				@(posedge clock);
				cycles++;
			end
			if (st_addr_q.size() <= s) begin
				errors++;
				timed_out = 1'b1;
				$display("test %s: no store %0d seen within %0d cycles", t_name[t], s,
					store_timeout);
			end else begin
				compare(t_name[t], $sformatf("store %0d addr", s), t_addr[t][s], st_addr_q[s]);
				compare(t_name[t], $sformatf("store %0d data", s), t_data[t][s], st_data_q[s]);
			end
		end
		// nothing else may be stored afterwards
		if (!timed_out) begin
			repeat (20) @(posedge clock);
			compare(t_name[t], "store count", t_nst[t], st_addr_q.size());
		end
		if (errors != start_errors) begin
			failed_tests++;
			$display("test %s: failed", t_name[t]);
		end else begin
			$display("test %s: ok", t_name[t]);
		end
	endtask

	initial begin
		clock = 1'b0;
		reset = 1'b0;
		stall_en = 1'b0;
		errors = 0;
		failed_tests = 0;
		build_table();
		for (int t = 0; t < n_tests; t++) begin
			run_test(t);
		end
		$display("tests %0d, failed %0d, check errors %0d", n_tests, failed_tests, errors);
		if (errors == 0) begin
			$display("*** PASSED ***");
		end else begin
			$display("*** FAILED ***");
		end
		$finish;
	end

endmodule

// ==== verif/tb_rv_mem.sv ====
module tb_rv_mem (
	input  logic          clock_i,
	input  logic          reset_i,
	input  logic          stall_en_i,
	input  rv_pkg::word_t inst_addr_i,
	input  logic          data_req_i,
	input  logic          data_wren_i,
	input  rv_pkg::word_t data_addr_i,
	input  rv_pkg::word_t data_wdata_i,
	output logic          inst_done_o,
	output rv_pkg::word_t inst_data_o,
	output logic          data_done_o,
	output rv_pkg::word_t data_rdata_o
);
	timeunit 1ns;
	timeprecision 100ps;

	// addi x0,x0,0
	localparam rv_pkg::word_t nop_word = 32'h00000013;

	// program words, loaded by the testbench
	rv_pkg::word_t imem [64];
	// data words, preset while reset is low
	rv_pkg::word_t dmem [256];

	// anything past the program area reads as a nop
	function automatic rv_pkg::word_t read_inst(input rv_pkg::word_t addr);
		if (addr[31:8] != '0) begin
			return nop_word;
		end
		return imem[addr[7:2]];
	endfunction

	// every byte lane depends on the word index
	function automatic rv_pkg::word_t fill_word(input logic [7:0] idx);
		return {idx ^ 8'h5A, ~idx, idx, idx ^ 8'hC3};
	endfunction

	initial begin
		void'($urandom(32'he096));
		inst_done_o  = 1'b1;
		data_done_o  = 1'b1;
		inst_data_o  = nop_word;
		data_rdata_o = '0;
		forever begin
			@(posedge clock_i);
			// sample the request at the edge
			if (!reset_i) begin
				for (int i = 0; i < 256; i++) begin
					dmem[i] = fill_word(i[7:0]);
				end
				// the word the load tests read
				dmem[64] = 32'h8765F0A3;
			end else if (data_req_i && data_wren_i) begin
				dmem[data_addr_i[9:2]] = data_wdata_i;
			end
			// responses go out shortly after the edge
			#1;
			inst_data_o  = read_inst(inst_addr_i);
			data_rdata_o = dmem[data_addr_i[9:2]];
			if (stall_en_i) begin
				// roughly one cycle in four is busy
				inst_done_o = ($urandom % 4) != 0;
				data_done_o = ($urandom % 4) != 0;
			end else begin
				inst_done_o = 1'b1;
				data_done_o = 1'b1;
			end
		end
	end

endmodule

// ==== rtl/rv_hart.sv ====
module rv_hart #(
	parameter rv_pkg::word_t reset_pc_p = '0,
	parameter rv_pkg::word_t sp_init_p  = 32'h0003F000
) (
	input  logic          clock_i,
	input  logic          reset_i,
	// instruction memory, read only
	output logic          inst_req_o,
	output rv_pkg::word_t inst_addr_o,
	input  logic          inst_done_i,
	input  rv_pkg::word_t inst_data_i,
	// data memory, read and write
	output logic          data_req_o,
	output logic          data_wren_o,
	output rv_pkg::word_t data_addr_o,
	output rv_pkg::word_t data_data_o,
	input  logic          data_done_i,
	input  rv_pkg::word_t data_data_i
);

	// --------------------------------------------------
	// pipeline control
	// --------------------------------------------------

	logic advance;
	logic stall;

	// --------------------------------------------------
	// stage to stage wires
	// --------------------------------------------------

	// fetch to decode
	rv_pkg::word_t     fe_pc;

	// decode to operand fetch
	rv_pkg::op_class_e de_class;
	rv_pkg::func3_t    de_func3;
	rv_pkg::func7_t    de_func7;
	rv_pkg::reg_idx_t  de_rs1;
	rv_pkg::reg_idx_t  de_rs2;
	rv_pkg::reg_idx_t  de_rd;
	rv_pkg::word_t     de_imm;
	rv_pkg::word_t     de_pc;

	// operand fetch to execute
	rv_pkg::op_class_e of_class;
	rv_pkg::func3_t    of_func3;
	rv_pkg::func7_t    of_func7;
	rv_pkg::reg_idx_t  of_rd;
	rv_pkg::word_t     of_src1;
	rv_pkg::word_t     of_src2;
	rv_pkg::word_t     of_imm;
	rv_pkg::word_t     of_pc;
	rv_pkg::word_t     of_ldst_addr;
	rv_pkg::word_t     of_store_data;

	// execute to writeback, also forwarded back
	rv_pkg::op_class_e ex_class;
	rv_pkg::reg_idx_t  ex_rd;
	rv_pkg::func3_t    ex_func3;
	rv_pkg::word_t     ex_result;

	// writeback register write port
	logic              wb_we;
	rv_pkg::reg_idx_t  wb_rd;
	rv_pkg::word_t     wb_value;

	rv_fetch #(
		.reset_pc_p (reset_pc_p)
	) rv_fetch_i (
		.clock_i     (clock_i),
		.reset_i     (reset_i),
		.inst_done_i (inst_done_i),
		.data_done_i (data_done_i),
		.stall_i     (stall),
		.inst_req_o  (inst_req_o),
		.inst_addr_o (inst_addr_o),
		.advance_o   (advance),
		.pc_o        (fe_pc)
	);

	rv_decode rv_decode_i (
		.clock_i     (clock_i),
		.reset_i     (reset_i),
		.advance_i   (advance),
		.stall_i     (stall),
		.inst_data_i (inst_data_i),
		.pc_i        (fe_pc),
		.class_o     (de_class),
		.func3_o     (de_func3),
		.func7_o     (de_func7),
		.rs1_o       (de_rs1),
		.rs2_o       (de_rs2),
		.rd_o        (de_rd),
		.imm_o       (de_imm),
		.pc_o        (de_pc)
	);

	rv_operand_fetch #(
		.sp_init_p (sp_init_p)
	) rv_operand_fetch_i (
		.clock_i      (clock_i),
		.reset_i      (reset_i),
		.advance_i    (advance),
		.class_i      (de_class),
		.func3_i      (de_func3),
		.func7_i      (de_func7),
		.rs1_i        (de_rs1),
		.rs2_i        (de_rs2),
		.rd_i         (de_rd),
		.imm_i        (de_imm),
		.pc_i         (de_pc),
		.ex_class_i   (ex_class),
		.ex_rd_i      (ex_rd),
		.ex_result_i  (ex_result),
		.wb_we_i      (wb_we),
		.wb_rd_i      (wb_rd),
		.wb_value_i   (wb_value),
		.stall_o      (stall),
		.class_o      (of_class),
		.func3_o      (of_func3),
		.func7_o      (of_func7),
		.rd_o         (of_rd),
		.src1_o       (of_src1),
		.src2_o       (of_src2),
		.imm_o        (of_imm),
		.pc_o         (of_pc),
		.ldst_addr_o  (of_ldst_addr),
		.store_data_o (of_store_data)
	);

	rv_execute rv_execute_i (
		.clock_i      (clock_i),
		.reset_i      (reset_i),
		.advance_i    (advance),
		.stall_i      (stall),
		.class_i      (of_class),
		.func3_i      (of_func3),
		.func7_i      (of_func7),
		.rd_i         (of_rd),
		.src1_i       (of_src1),
		.src2_i       (of_src2),
		.imm_i        (of_imm),
		.pc_i         (of_pc),
		.ldst_addr_i  (of_ldst_addr),
		.store_data_i (of_store_data),
		.class_o      (ex_class),
		.rd_o         (ex_rd),
		.func3_o      (ex_func3),
		.result_o     (ex_result),
		.data_req_o   (data_req_o),
		.data_wren_o  (data_wren_o),
		.data_addr_o  (data_addr_o),
		.data_data_o  (data_data_o)
	);

	rv_writeback rv_writeback_i (
		.clock_i     (clock_i),
		.reset_i     (reset_i),
		.advance_i   (advance),
		.class_i     (ex_class),
		.rd_i        (ex_rd),
		.func3_i     (ex_func3),
		.result_i    (ex_result),
		.data_data_i (data_data_i),
		.we_o        (wb_we),
		.rd_o        (wb_rd),
		.value_o     (wb_value)
	);

endmodule

// ==== rtl/rv_writeback.sv ====
module rv_writeback (
	input  logic              clock_i,
	input  logic              reset_i,
	input  logic              advance_i,
	input  rv_pkg::op_class_e class_i,
	input  rv_pkg::reg_idx_t  rd_i,
	input  rv_pkg::func3_t    func3_i,
	input  rv_pkg::word_t     result_i,
	input  rv_pkg::word_t     data_data_i,
	output logic              we_o,
	output rv_pkg::reg_idx_t  rd_o,
	output rv_pkg::word_t     value_o
);

	rv_pkg::op_class_e class_q;
	rv_pkg::func3_t    func3_q;
	rv_pkg::word_t     result_q;
	// load word as it came back from memory
	rv_pkg::word_t     data_q;
	rv_pkg::word_t     load_val;

	always_ff @(posedge clock_i) begin
		if (!reset_i) begin
			class_q <= rv_pkg::op_none;
		end else if (advance_i) begin
			class_q <= class_i;
		end
	end

	always_ff @(posedge clock_i) begin
		if (advance_i) begin
			rd_o     <= rd_i;
			func3_q  <= func3_i;
			result_q <= result_i;
		end
		// the data request went out on the previous advance
		if (advance_i && class_i == rv_pkg::op_load) begin
			data_q <= data_data_i;
		end
	end

	// sign or zero extension of the low lanes
	always_comb begin
		case (func3_q)
			rv_pkg::f3_lb:  load_val = {{24{data_q[7]}}, data_q[7:0]};
			rv_pkg::f3_lh:  load_val = {{16{data_q[15]}}, data_q[15:0]};
			rv_pkg::f3_lbu: load_val = {24'b0, data_q[7:0]};
			rv_pkg::f3_lhu: load_val = {16'b0, data_q[15:0]};
			default:        load_val = data_q;
		endcase
	end

	assign value_o = (class_q == rv_pkg::op_load) ? load_val : result_q;

	// x0 is never written, stores and bubbles never write
	assign we_o = (rd_o != '0) && (class_q inside {rv_pkg::op_lui, rv_pkg::op_auipc,
		rv_pkg::op_alu_imm, rv_pkg::op_alu_reg, rv_pkg::op_load});

	we_not_x0_a: assert property (@(posedge clock_i) disable iff (!reset_i)
		we_o |-> rd_o != '0);

endmodule

// ==== rtl/rv_execute.sv ====
module rv_execute (
	input  logic              clock_i,
	input  logic              reset_i,
	input  logic              advance_i,
	input  logic              stall_i,
	input  rv_pkg::op_class_e class_i,
	input  rv_pkg::func3_t    func3_i,
	input  rv_pkg::func7_t    func7_i,
	input  rv_pkg::reg_idx_t  rd_i,
	input  rv_pkg::word_t     src1_i,
	input  rv_pkg::word_t     src2_i,
	input  rv_pkg::word_t     imm_i,
	input  rv_pkg::word_t     pc_i,
	input  rv_pkg::word_t     ldst_addr_i,
	input  rv_pkg::word_t     store_data_i,
	output rv_pkg::op_class_e class_o,
	output rv_pkg::reg_idx_t  rd_o,
	output rv_pkg::func3_t    func3_o,
	output rv_pkg::word_t     result_o,
	output logic              data_req_o,
	output logic              data_wren_o,
	output rv_pkg::word_t     data_addr_o,
	output rv_pkg::word_t     data_data_o
);

	rv_pkg::func7_t func7_q;
	rv_pkg::word_t  src1_q;
	rv_pkg::word_t  src2_q;
	rv_pkg::word_t  imm_q;
	rv_pkg::word_t  pc_q;

	// second alu operand and alu output
	rv_pkg::word_t  op_b;
	rv_pkg::word_t  alu;
	logic           is_ldst;

	assign is_ldst = class_i inside {rv_pkg::op_load, rv_pkg::op_store};

	// --------------------------------------------------
	// stage register and memory request
	// --------------------------------------------------

	always_ff @(posedge clock_i) begin
		if (!reset_i) begin
			class_o     <= rv_pkg::op_none;
			data_req_o  <= 1'b0;
			data_wren_o <= 1'b0;
		end else begin
			// strobes last a single cycle
			data_req_o  <= advance_i && !stall_i && is_ldst;
			data_wren_o <= advance_i && !stall_i && (class_i == rv_pkg::op_store);
			// a stall leaves a bubble behind the load
			if (advance_i) begin
				class_o <= stall_i ? rv_pkg::op_none : class_i;
			end
		end
	end

	always_ff @(posedge clock_i) begin
		if (advance_i) begin
			rd_o    <= rd_i;
			func3_o <= func3_i;
			func7_q <= func7_i;
			src1_q  <= src1_i;
			src2_q  <= src2_i;
			imm_q   <= imm_i;
			pc_q    <= pc_i;
		end
		if (advance_i && !stall_i && is_ldst) begin
			data_addr_o <= ldst_addr_i;
			data_data_o <= store_data_i;
		end
	end

	// --------------------------------------------------
	// alu
	// --------------------------------------------------

	assign op_b = (class_o == rv_pkg::op_alu_reg) ? src2_q : imm_q;

	always_comb begin
		case (func3_o)
			rv_pkg::f3_add: begin
				// addi has no subtract form
				if (func7_q[5] && class_o == rv_pkg::op_alu_reg) begin
					alu = src1_q - op_b;
				end else begin
					alu = src1_q + op_b;
				end
			end
			rv_pkg::f3_sll:  alu = src1_q << op_b[4:0];
			rv_pkg::f3_slt:  alu = rv_pkg::word_t'($signed(src1_q) < $signed(op_b));
			rv_pkg::f3_sltu: alu = rv_pkg::word_t'(src1_q < op_b);
			rv_pkg::f3_xor:  alu = src1_q ^ op_b;
			rv_pkg::f3_srl: begin
				// srai carries the same func7 bit as sra
				if (func7_q[5]) begin
					alu = $signed(src1_q) >>> op_b[4:0];
				end else begin
					alu = src1_q >> op_b[4:0];
				end
			end
			rv_pkg::f3_or:   alu = src1_q | op_b;
			default:         alu = src1_q & op_b;
		endcase
	end

	// result select by class
	// loads and stores carry no result here
	always_comb begin
		case (class_o)
			rv_pkg::op_lui:                       result_o = imm_q;
			rv_pkg::op_auipc:                     result_o = pc_q + imm_q;
			rv_pkg::op_alu_imm, rv_pkg::op_alu_reg: result_o = alu;
			default:                              result_o = '0;
		endcase
	end

	wren_has_req_a: assert property (@(posedge clock_i) disable iff (!reset_i)
		data_wren_o |-> data_req_o);

endmodule

// ==== rtl/rv_operand_fetch.sv ====
module rv_operand_fetch #(
	parameter rv_pkg::word_t sp_init_p = 32'h0003F000
) (
	input  logic              clock_i,
	input  logic              reset_i,
	input  logic              advance_i,
	input  rv_pkg::op_class_e class_i,
	input  rv_pkg::func3_t    func3_i,
	input  rv_pkg::func7_t    func7_i,
	input  rv_pkg::reg_idx_t  rs1_i,
	input  rv_pkg::reg_idx_t  rs2_i,
	input  rv_pkg::reg_idx_t  rd_i,
	input  rv_pkg::word_t     imm_i,
	input  rv_pkg::word_t     pc_i,
	input  rv_pkg::op_class_e ex_class_i,
	input  rv_pkg::reg_idx_t  ex_rd_i,
	input  rv_pkg::word_t     ex_result_i,
	input  logic              wb_we_i,
	input  rv_pkg::reg_idx_t  wb_rd_i,
	input  rv_pkg::word_t     wb_value_i,
	output logic              stall_o,
	output rv_pkg::op_class_e class_o,
	output rv_pkg::func3_t    func3_o,
	output rv_pkg::func7_t    func7_o,
	output rv_pkg::reg_idx_t  rd_o,
	output rv_pkg::word_t     src1_o,
	output rv_pkg::word_t     src2_o,
	output rv_pkg::word_t     imm_o,
	output rv_pkg::word_t     pc_o,
	output rv_pkg::word_t     ldst_addr_o,
	output rv_pkg::word_t     store_data_o
);

	rv_pkg::word_t    rf_q [32];
	rv_pkg::reg_idx_t rs1_q;
	rv_pkg::reg_idx_t rs2_q;

	// which sources the held instruction really reads
	logic use_rs1;
	logic use_rs2;
	// execute holds a result that can be forwarded now
	logic ex_fwd;

	// --------------------------------------------------
	// register file
	// --------------------------------------------------

	// x2 starts as the stack pointer
	always_ff @(posedge clock_i) begin
		if (!reset_i) begin
			for (int i = 0; i < 32; i++) begin
				rf_q[i] <= (i == 2) ? sp_init_p : '0;
			end
		end else if (advance_i && wb_we_i) begin
			rf_q[wb_rd_i] <= wb_value_i;
		end
	end

	// --------------------------------------------------
	// stage register
	// --------------------------------------------------

	always_ff @(posedge clock_i) begin
		if (!reset_i) begin
			class_o <= rv_pkg::op_none;
		end else if (advance_i && !stall_o) begin
			class_o <= class_i;
		end
	end

	always_ff @(posedge clock_i) begin
		if (advance_i && !stall_o) begin
			func3_o <= func3_i;
			func7_o <= func7_i;
			rs1_q   <= rs1_i;
			rs2_q   <= rs2_i;
			rd_o    <= rd_i;
			imm_o   <= imm_i;
			pc_o    <= pc_i;
		end
	end

	// --------------------------------------------------
	// hazards and forwarding
	// --------------------------------------------------

	assign use_rs1 = class_o inside {rv_pkg::op_alu_imm, rv_pkg::op_alu_reg,
		rv_pkg::op_load, rv_pkg::op_store};
	assign use_rs2 = class_o inside {rv_pkg::op_alu_reg, rv_pkg::op_store};

	// load data only exists one stage later, so hold one advance
	assign stall_o = (ex_class_i == rv_pkg::op_load) && (ex_rd_i != '0) &&
		((use_rs1 && rs1_q == ex_rd_i) || (use_rs2 && rs2_q == ex_rd_i));

	assign ex_fwd = ex_class_i inside {rv_pkg::op_lui, rv_pkg::op_auipc,
		rv_pkg::op_alu_imm, rv_pkg::op_alu_reg};

	// youngest value wins
	function automatic rv_pkg::word_t read_src(input rv_pkg::reg_idx_t idx);
		if (idx == '0) begin
			return '0;
		end else if (ex_fwd && ex_rd_i == idx) begin
			return ex_result_i;
		end else if (wb_we_i && wb_rd_i == idx) begin
			return wb_value_i;
		end
		return rf_q[idx];
	endfunction

	always_comb begin
		src1_o = read_src(rs1_q);
		src2_o = read_src(rs2_q);
	end

	// memory address and store word for the request in execute
	assign ldst_addr_o  = src1_o + imm_o;
	assign store_data_o = src2_o;

	stall_has_insn_a: assert property (@(posedge clock_i) disable iff (!reset_i)
		stall_o |-> class_o != rv_pkg::op_none);

endmodule

// ==== rtl/rv_decode.sv ====
module rv_decode (
	input  logic              clock_i,
	input  logic              reset_i,
	input  logic              advance_i,
	input  logic              stall_i,
	input  rv_pkg::word_t     inst_data_i,
	input  rv_pkg::word_t     pc_i,
	output rv_pkg::op_class_e class_o,
	output rv_pkg::func3_t    func3_o,
	output rv_pkg::func7_t    func7_o,
	output rv_pkg::reg_idx_t  rs1_o,
	output rv_pkg::reg_idx_t  rs2_o,
	output rv_pkg::reg_idx_t  rd_o,
	output rv_pkg::word_t     imm_o,
	output rv_pkg::word_t     pc_o
);

	// instruction register and its address
	rv_pkg::word_t ir_q;
	rv_pkg::word_t pc_q;

	// valid_q marks ir_q as holding a real instruction
	logic valid_q;

	// --------------------------------------------------
	// instruction register
	// --------------------------------------------------

	always_ff @(posedge clock_i) begin
		if (!reset_i) begin
			valid_q <= 1'b0;
		end else if (advance_i && !stall_i) begin
			// set by the first word that arrives after reset
			valid_q <= 1'b1;
		end
	end

	always_ff @(posedge clock_i) begin
		if (advance_i && !stall_i) begin
			ir_q <= inst_data_i;
			pc_q <= pc_i;
		end
	end

	// --------------------------------------------------
	// field extraction and class decode
	// --------------------------------------------------

	assign func3_o = ir_q[14:12];
	assign func7_o = ir_q[31:25];
	assign rs1_o   = ir_q[19:15];
	assign rs2_o   = ir_q[24:20];
	assign pc_o    = pc_q;

	always_comb begin
		case (ir_q[6:0])
			rv_pkg::opc_lui:    class_o = rv_pkg::op_lui;
			rv_pkg::opc_auipc:  class_o = rv_pkg::op_auipc;
			rv_pkg::opc_op_imm: class_o = rv_pkg::op_alu_imm;
			rv_pkg::opc_op:     class_o = rv_pkg::op_alu_reg;
			rv_pkg::opc_load:   class_o = rv_pkg::op_load;
			rv_pkg::opc_store:  class_o = rv_pkg::op_store;
			// anything else travels as a bubble
			default:            class_o = rv_pkg::op_none;
		endcase
		if (!valid_q) begin
			class_o = rv_pkg::op_none;
		end
	end

	// stores and bubbles never name a destination
	assign rd_o = (class_o inside {rv_pkg::op_store, rv_pkg::op_none}) ? '0 : ir_q[11:7];

	// immediate by format
	always_comb begin
		case (class_o)
			// s-type splits the offset around rd
			rv_pkg::op_store:
				imm_o = {{20{ir_q[31]}}, ir_q[31:25], ir_q[11:7]};
			// u-type upper twenty bits
			rv_pkg::op_lui, rv_pkg::op_auipc:
				imm_o = {ir_q[31:12], 12'b0};
			// i-type for loads and alu immediates
			default:
				imm_o = {{20{ir_q[31]}}, ir_q[31:20]};
		endcase
	end

endmodule

// ==== rtl/rv_fetch.sv ====
module rv_fetch #(
	parameter rv_pkg::word_t reset_pc_p = '0
) (
	input  logic          clock_i,
	input  logic          reset_i,
	input  logic          inst_done_i,
	input  logic          data_done_i,
	input  logic          stall_i,
	output logic          inst_req_o,
	output rv_pkg::word_t inst_addr_o,
	output logic          advance_o,
	output rv_pkg::word_t pc_o
);

	// next address to request
	rv_pkg::word_t pc_q;

	// the whole pipeline moves only when both memories are done
	assign advance_o = inst_done_i && data_done_i;

	// the word arriving now belongs to the last requested address
	assign pc_o = inst_addr_o;

	always_ff @(posedge clock_i) begin
		if (!reset_i) begin
			// first request goes out straight after reset
			inst_req_o  <= 1'b1;
			inst_addr_o <= reset_pc_p;
			pc_q        <= reset_pc_p + 32'd4;
		end else begin
			// one strobe per advance
			inst_req_o <= advance_o;
			// on stall the same address goes out again
			if (advance_o && !stall_i) begin
				inst_addr_o <= pc_q;
				pc_q        <= pc_q + 32'd4;
			end
		end
	end

endmodule

// ==== rtl/rv_pkg.sv ====
package rv_pkg;

	// --------------------------------------------------
	// widths and vector types
	// --------------------------------------------------

	// data and address width of the hart
	localparam int xlen = 32;

	// register values, addresses and instruction words
	typedef logic [xlen-1:0] word_t;

	// register file index
	typedef logic [4:0] reg_idx_t;

	// instruction sub-fields
	typedef logic [2:0] func3_t;
	typedef logic [6:0] func7_t;

	// operation classes carried down the pipeline
	// op_none is an empty slot
	typedef enum logic [2:0] {
		op_none,
		op_lui,
		op_auipc,
		op_alu_imm,
		op_alu_reg,
		op_load,
		op_store
	} op_class_e;

	// --------------------------------------------------
	// opcodes
	// --------------------------------------------------

	localparam logic [6:0] opc_lui    = 7'b0110111;
	localparam logic [6:0] opc_auipc  = 7'b0010111;
	localparam logic [6:0] opc_op_imm = 7'b0010011;
	localparam logic [6:0] opc_op     = 7'b0110011;
	localparam logic [6:0] opc_load   = 7'b0000011;
	localparam logic [6:0] opc_store  = 7'b0100011;

	// --------------------------------------------------
	// func3 encodings
	// --------------------------------------------------

	// load widths
	localparam func3_t f3_lb  = 3'b000;
	localparam func3_t f3_lh  = 3'b001;
	localparam func3_t f3_lw  = 3'b010;
	localparam func3_t f3_lbu = 3'b100;
	localparam func3_t f3_lhu = 3'b101;

	// alu operations
	// func7 bit 5 turns add into sub and srl into sra
	localparam func3_t f3_add  = 3'b000;
	localparam func3_t f3_sll  = 3'b001;
	localparam func3_t f3_slt  = 3'b010;
	localparam func3_t f3_sltu = 3'b011;
	localparam func3_t f3_xor  = 3'b100;
	localparam func3_t f3_srl  = 3'b101;
	localparam func3_t f3_or   = 3'b110;
	localparam func3_t f3_and  = 3'b111;

endpackage
